// ==== list.f ====
rtl/sa_geom_pkg.sv
rtl/quant_pkg.sv
rtl/relu_quantize.sv
rtl/postproc_cfg.sv
rtl/postproc_pipe.sv
rtl/postproc_top.sv
test/tb_postproc.sv

// ==== rtl/postproc_cfg.sv ====
`timescale 1ns/1ps

module postproc_cfg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_we,
  input  quant_pkg::cfg_addr_t   cfg_addr,
  input  quant_pkg::cfg_data_t   cfg_data,
  output quant_pkg::quant_mode_e mode,
  output quant_pkg::scale_t      scale_0,
  output quant_pkg::scale_t      scale_1,
  output quant_pkg::bias_t       bias_0,
  output quant_pkg::bias_t       bias_1
);

  import quant_pkg::*;

  localparam int mode_width = $bits(quant_mode_e);

  ////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode    <= mode_8x8;
      scale_0 <= '0;
      scale_1 <= '0;
      bias_0  <= '0;
      bias_1  <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        cfg_addr_mode: begin
          // unknown codes are kept, the quantizer zeroes them
          mode <= quant_mode_e'(cfg_data[mode_width-1:0]);
        end
        cfg_addr_scale: begin
          scale_0 <= cfg_data[scale_width-1:0];
          scale_1 <= cfg_data[2*scale_width-1:scale_width];
        end
        cfg_addr_bias_0: begin
          bias_0 <= bias_t'(cfg_data);
        end
        cfg_addr_bias_1: begin
          bias_1 <= bias_t'(cfg_data);
        end
      endcase
    end
  end

endmodule

// ==== rtl/postproc_pipe.sv ====
`timescale 1ns/1ps

module postproc_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  input  quant_pkg::quant_mode_e    mode,
  input  quant_pkg::scale_t         scale_0,
  input  quant_pkg::scale_t         scale_1,
  input  quant_pkg::bias_t          bias_0,
  input  quant_pkg::bias_t          bias_1,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  sa_geom_pkg::product_vec_t in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output sa_geom_pkg::quant_vec_t   out_data
);

  import sa_geom_pkg::*;
  import quant_pkg::*;

  stage_state_e s1_state;
  stage_state_e s2_state;
  product_vec_t s1_data;
  quant_vec_t   s2_data;
  product_vec_t biased_in;
  quant_vec_t   quant_next;
  logic         in_fire;
  logic         s2_ready;
  logic         s1_advance;

  ////////////////////////////////////////////////////
  // bias add with 40 bit wrap
  ////////////////////////////////////////////////////

  for (genvar i = 0; i < lane_num; i++) begin : g_bias
    product_t acc;
    bias_t    lane_bias;

    assign acc       = in_data[i*mult_p_width +: mult_p_width];
    // channel 0 owns the lower lanes
    assign lane_bias = (i < lanes_per_channel) ? bias_0 : bias_1;
    assign biased_in[i*mult_p_width +: mult_p_width] = acc + lane_bias;
  end

  ////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////

  // stage two can take a beat if empty or draining this cycle
  assign s2_ready   = (s2_state == stage_empty) || out_ready;
  assign s1_advance = (s1_state == stage_full) && s2_ready;
  assign in_ready   = (s1_state == stage_empty) || s2_ready;
  assign in_fire    = in_valid && in_ready;

  assign out_valid  = (s2_state == stage_full);
  assign out_data   = s2_data;

  // stage one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_state <= stage_empty;
    end else if (in_fire) begin
      s1_state <= stage_full;
    end else if (s1_advance) begin
      s1_state <= stage_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      s1_data <= biased_in;
    end
  end

  relu_quantize u_relu_quantize (
    .mode      (mode),
    .scale_0   (scale_0),
    .scale_1   (scale_1),
    .biased    (s1_data),
    .quantized (quant_next)
  );

  // stage two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_state <= stage_empty;
    end else if (s1_advance) begin
      s2_state <= stage_full;
    end else if (out_ready) begin
      s2_state <= stage_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_advance) begin
      s2_data <= quant_next;
    end
  end

endmodule

// ==== rtl/postproc_top.sv ====
`timescale 1ns/1ps

module postproc_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  quant_pkg::cfg_addr_t      cfg_addr,
  input  logic                      cfg_we,
  input  quant_pkg::cfg_data_t      cfg_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  sa_geom_pkg::product_vec_t in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output sa_geom_pkg::quant_vec_t   out_data
);

  import quant_pkg::*;

  quant_mode_e mode;
  scale_t      scale_0;
  scale_t      scale_1;
  bias_t       bias_0;
  bias_t       bias_1;

  ////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////

  postproc_cfg u_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .mode     (mode),
    .scale_0  (scale_0),
    .scale_1  (scale_1),
    .bias_0   (bias_0),
    .bias_1   (bias_1)
  );

  ////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////

  postproc_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .scale_0   (scale_0),
    .scale_1   (scale_1),
    .bias_0    (bias_0),
    .bias_1    (bias_1),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// ==== rtl/quant_pkg.sv ====
package quant_pkg;

  // right shift amount per channel
  localparam int scale_width = 8;

  typedef logic [scale_width-1:0] scale_t;
  typedef logic signed [sa_geom_pkg::mult_p_width-1:0] bias_t;

  // only two precision modes are decoded, the rest quantize to zero
  typedef enum logic [3:0] {
    mode_8x8 = 4'd0,
    mode_1x8 = 4'd1
  } quant_mode_e;

  ////////////////////////////////////////////////////
  // configuration write port
  ////////////////////////////////////////////////////

  typedef logic [1:0] cfg_addr_t;
  typedef logic [sa_geom_pkg::mult_p_width-1:0] cfg_data_t;

  localparam cfg_addr_t cfg_addr_mode   = 2'd0;
  localparam cfg_addr_t cfg_addr_scale  = 2'd1;
  localparam cfg_addr_t cfg_addr_bias_0 = 2'd2;
  localparam cfg_addr_t cfg_addr_bias_1 = 2'd3;

  // occupancy of one pipeline register
  typedef enum logic {
    stage_empty = 1'b0,
    stage_full  = 1'b1
  } stage_state_e;

endpackage

// ==== rtl/relu_quantize.sv ====
`timescale 1ns/1ps

module relu_quantize (
  input  quant_pkg::quant_mode_e    mode,
  input  quant_pkg::scale_t         scale_0,
  input  quant_pkg::scale_t         scale_1,
  input  sa_geom_pkg::product_vec_t biased,
  output sa_geom_pkg::quant_vec_t   quantized
);

  import sa_geom_pkg::*;
  import quant_pkg::*;

  localparam logic [mult_p_width-1:0] sat_max = mult_p_width'(2**quant_pixel_width - 1);

  logic lo_en;
  logic hi_en;

  // relu, logical shift, clamp to 255
  function automatic logic [quant_pixel_width-1:0] quant_lane(
    input product_t value,
    input scale_t   shift
  );
    logic [mult_p_width-1:0] shifted;
    shifted = $unsigned(value) >> shift;
    if (value[mult_p_width-1]) begin
      return '0;
    end
    if (shifted > sat_max) begin
      return {quant_pixel_width{1'b1}};
    end
    return shifted[quant_pixel_width-1:0];
  endfunction

  // lower half is live in both modes, upper half only in 1x8
  assign lo_en = (mode == mode_8x8) || (mode == mode_1x8);
  assign hi_en = (mode == mode_1x8);

  ////////////////////////////////////////////////////
  // channel 0 lanes
  ////////////////////////////////////////////////////

  for (genvar i = 0; i < lanes_per_channel; i++) begin : g_lo
    product_t lane;

    assign lane = biased[i*mult_p_width +: mult_p_width];
    assign quantized[i*quant_pixel_width +: quant_pixel_width] =
      lo_en ? quant_lane(lane, scale_0) : '0;
  end

  ////////////////////////////////////////////////////
  // channel 1 lanes
  ////////////////////////////////////////////////////

  for (genvar i = lanes_per_channel; i < lane_num; i++) begin : g_hi
    product_t lane;

    assign lane = biased[i*mult_p_width +: mult_p_width];
    // 8x8 carries a single weight channel, so this half is forced to zero
    assign quantized[i*quant_pixel_width +: quant_pixel_width] =
      hi_en ? quant_lane(lane, scale_1) : '0;
  end

endmodule

// ==== rtl/sa_geom_pkg.sv ====
package sa_geom_pkg;

  ////////////////////////////////////////////////////
  // systolic array geometry
  ////////////////////////////////////////////////////

  localparam int column_num_in_sa   = 16;
  // pixels and weight channels per processing element
  localparam int pe_parallel_pixel  = 2;
  localparam int pe_parallel_weight = 2;

  // one channel half holds every pixel of every column
  localparam int lanes_per_channel  = pe_parallel_pixel * column_num_in_sa;
  localparam int lane_num           = lanes_per_channel * pe_parallel_weight;

  ////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////

  localparam int mult_p_width       = 40;
  localparam int quant_pixel_width  = 8;

  // 40 bit x 32 pixels x 2 channels
  typedef logic [lane_num*mult_p_width-1:0] product_vec_t;
  // 8 bit x 32 pixels x 2 channels
  typedef logic [lane_num*quant_pixel_width-1:0] quant_vec_t;

  // single accumulator lane
  typedef logic signed [mult_p_width-1:0] product_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the postproc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_postproc -o tb_postproc
./obj_dir/tb_postproc | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== test/tb_postproc.sv ====
`timescale 1ns/1ps

module tb_postproc;

  import sa_geom_pkg::*;
  import quant_pkg::*;

  localparam int n_directed  = 8;
  localparam int n_random    = 60;
  localparam int n_bad_mode  = 4;
  localparam int total_beats = 3 * n_directed + n_random + n_bad_mode;
  localparam int cycle_limit = 4 * total_beats + 200;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         cfg_we;
  cfg_addr_t    cfg_addr;
  cfg_data_t    cfg_data;
  logic         in_valid;
  logic         in_ready;
  product_vec_t in_data;
  logic         out_valid;
  logic         out_ready;
  quant_vec_t   out_data;

  // model copy of the configuration registers
  logic [3:0]  m_mode;
  logic [7:0]  m_scale_0;
  logic [7:0]  m_scale_1;
  logic [39:0] m_bias_0;
  logic [39:0] m_bias_1;

  quant_vec_t  exp_q [$];
  quant_vec_t  exp_vec;
  int          mismatches = 0;
  int          failures = 0;
  int          cycles = 0;
  int          n_in = 0;
  int          n_out = 0;
  logic        rand_ready = 1'b0;

  postproc_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_addr  (cfg_addr),
    .cfg_we    (cfg_we),
    .cfg_data  (cfg_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [7:0] expect_lane(logic [39:0] acc, logic [39:0] bias,
                                             logic [7:0] shift);
    logic [39:0] sum;
    logic [39:0] sh;
    sum = acc + bias;
    if (sum[39]) begin
      return 8'd0;
    end
    sh = sum >> shift;
    if (sh > 40'd255) begin
      return 8'd255;
    end
    return sh[7:0];
  endfunction

  function automatic quant_vec_t expect_vec(product_vec_t vec);
    quant_vec_t  res;
    logic [39:0] acc;
    res = '0;
    for (int i = 0; i < lane_num; i++) begin
      acc = vec[i*mult_p_width +: mult_p_width];
      if (i < lanes_per_channel && (m_mode == 4'd0 || m_mode == 4'd1)) begin
        res[i*quant_pixel_width +: quant_pixel_width] = expect_lane(acc, m_bias_0, m_scale_0);
      end else if (i >= lanes_per_channel && m_mode == 4'd1) begin
        res[i*quant_pixel_width +: quant_pixel_width] = expect_lane(acc, m_bias_1, m_scale_1);
      end
    end
    return res;
  endfunction

  // kind 0 positive, 1 saturation edges, 2 small values for bias, 3 anything
  function automatic logic [39:0] make_lane(int kind, int idx);
    logic [39:0] v;
    logic [7:0]  s;
    s = (idx < lanes_per_channel) ? m_scale_0 : m_scale_1;
    v = {8'($urandom), 32'($urandom)};
    if (kind == 0 || (kind == 1 && idx % 8 == 7)) begin
      v = {1'b0, v[38:0]} >> ($urandom % 40);
    end else if (kind == 1) begin
      case (idx % 8)
        0: v = 40'h7f_ffff_ffff;
        1: v = '1;
        2: v = 40'd255 << s;
        3: v = (40'd256 << s) - 40'd1;
        4: v = 40'd256 << s;
        5: v = (40'd255 << s) - 40'd1;
        default: v = 40'h80_0000_0000;
      endcase
    end else if (kind == 2) begin
      v = (idx % 8 == 0) ? 40'h7f_ffff_ff00 : 40'($urandom % 2048);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // drivers entered on a falling edge
  //////////////////////////////////////////////////

  task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
    cfg_we   = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    @(negedge clk);
    cfg_we = 1'b0;
    case (addr)
      cfg_addr_mode: m_mode = data[3:0];
      cfg_addr_scale: begin
        m_scale_0 = data[7:0];
        m_scale_1 = data[15:8];
      end
      cfg_addr_bias_0: m_bias_0 = data;
      default: m_bias_1 = data;
    endcase
  endtask

  task automatic send_beat(input product_vec_t vec);
    in_valid = 1'b1;
    in_data  = vec;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0t: %0d beats never left the pipeline", $time, exp_q.size());
      failures++;
      exp_q.delete();
    end
    @(negedge clk);
  endtask

  task automatic send_phase(input int kind, input int count, input bit gaps);
    product_vec_t vec;
    for (int b = 0; b < count; b++) begin
      for (int i = 0; i < lane_num; i++) begin
        vec[i*mult_p_width +: mult_p_width] = make_lane(kind, i);
      end
      while (gaps && $urandom % 3 == 0) begin
        @(negedge clk);
      end
      send_beat(vec);
    end
    drain_pipe();
  endtask

  always @(negedge clk) begin
    if (rand_ready) begin
      out_ready = ($urandom % 4) != 0;
    end
  end

  //////////////////////////////////////////////////
  // monitor and checks
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (rst_n && in_valid && in_ready) begin
      exp_q.push_back(expect_vec(in_data));
      n_in++;
    end
    if (rst_n && out_valid && out_ready) begin
      n_out++;
      assert (exp_q.size() != 0) else begin
        $display("%0t: output beat arrived with no beat expected", $time);
        failures++;
      end
      if (exp_q.size() != 0) begin
        exp_vec = exp_q.pop_front();
        assert (out_data == exp_vec) else begin
          $display("MISMATCH %0t out_data got %h expected %h", $time, out_data, exp_vec);
          mismatches++;
        end
      end
    end
    if (cycles >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // a stalled output beat must hold
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
  else begin
    $display("%0t: output beat changed or dropped while out_ready was low", $time);
    failures++;
  end

  initial begin
    void'($urandom(32'hc9d29468));
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    m_mode    = 4'd0;
    m_scale_0 = 8'd0;
    m_scale_1 = 8'd0;
    m_bias_0  = 40'd0;
    m_bias_1  = 40'd0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) begin
      @(posedge clk);
      assert (!out_valid && in_ready) else begin
        $display("%0t: pipeline not idle after reset, out_valid=%b in_ready=%b",
                 $time, out_valid, in_ready);
        failures++;
      end
    end
    @(negedge clk);
    // 8x8 keeps the upper half at zero
    write_cfg(cfg_addr_scale, 40'h0904);
    send_phase(0, n_directed, 1'b0);
    write_cfg(cfg_addr_mode, 40'd1);
    write_cfg(cfg_addr_scale, 40'h0502);
    send_phase(1, n_directed, 1'b0);
    // bias of -1000 and +500
    write_cfg(cfg_addr_bias_0, 40'hff_ffff_fc18);
    write_cfg(cfg_addr_bias_1, 40'd500);
    write_cfg(cfg_addr_scale, 40'h0301);
    send_phase(2, n_directed, 1'b0);
    write_cfg(cfg_addr_scale, 40'h0703);
    rand_ready = 1'b1;
    send_phase(3, n_random, 1'b1);
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    // undecoded mode
    write_cfg(cfg_addr_mode, 40'd5);
    send_phase(3, n_bad_mode, 1'b0);
    assert (n_in == total_beats && n_out == total_beats) else begin
      $display("beat count wrong, %0d accepted and %0d delivered of %0d",
               n_in, n_out, total_beats);
      failures++;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
